/* design/at_resp_pkg.sv */
package at_resp_pkg;

	localparam int BYTE_W = 8; // One UART character.
	localparam int WORD_W = 16; // Read word, two characters.
	localparam int CNT_W = 10; // Bit-time and cycle counters.

	// Response handler states.
	typedef enum logic [2:0] {
		IDLE, // Waiting for start.
		ARMED, // Armed, no byte seen yet.
		COLLECT, // Bytes arriving, silence timer running.
		PAD, // Odd length, one filler byte.
		DONE // Response complete.
	} at_state_t;

endpackage

/* design/rfifo_if.sv */
interface rfifo_if #(
	parameter int DEPTH_BYTES = 128
);
	import at_resp_pkg::*;

	logic [BYTE_W-1:0] wr_data;
	logic wr_en; // One-cycle strobe, no back-pressure.
	logic full;
	logic empty; // Fewer than two bytes held.
	logic [$clog2(DEPTH_BYTES):0] wr_count; // Bytes held.

	modport writer (
		output wr_data,
		output wr_en,
		input full,
		input empty
	);

	modport fifo (
		input wr_data,
		input wr_en,
		output full,
		output empty,
		output wr_count
	);

endinterface

/* design/uart_rx.sv */
module uart_rx #(
	parameter int CPD = 50
) (
	input logic clock,
	input logic rst_n,
	input logic rx_line,
	output logic [at_resp_pkg::BYTE_W-1:0] rx_data,
	output logic rx_valid,
	output logic rx_busy
);
	import at_resp_pkg::*;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP,
		RX_TAIL
	} rx_state_t;

	localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CPD / 2 - 1);
	localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(CPD - 1);

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic [CNT_W-1:0] clk_cnt;
	logic [2:0] bit_idx;
	logic [BYTE_W-1:0] shift;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1; // Idle line is high.
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev & ~rx_sync;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			clk_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			case (state)
			RX_IDLE: begin
				clk_cnt <= '0;
				if (start_edge)
					state <= RX_START;
			end
			RX_START: begin
				if (clk_cnt == HALF_LAST) begin
					clk_cnt <= '0;
					bit_idx <= '0;
					// Glitch if the line is high again at mid-bit.
					state <= rx_sync ? RX_IDLE : RX_DATA;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			RX_DATA: begin
				if (clk_cnt == BIT_LAST) begin
					clk_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= RX_STOP;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			RX_STOP: begin
				if (clk_cnt == BIT_LAST) begin
					clk_cnt <= '0;
					rx_valid <= rx_sync; // Low stop bit drops the byte.
					state <= RX_TAIL;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			RX_TAIL: begin
				if (start_edge) begin
					clk_cnt <= '0;
					state <= RX_START; // Back-to-back character.
				end else if (clk_cnt == HALF_LAST) begin
					clk_cnt <= '0;
					state <= RX_IDLE;
				end else begin
					clk_cnt <= clk_cnt + 1'b1;
				end
			end
			default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB first.
	always_ff @(posedge clock) begin
		if (state == RX_DATA && clk_cnt == BIT_LAST)
			shift <= {rx_sync, shift[BYTE_W-1:1]};
	end

	assign rx_data = shift;
	assign rx_busy = (state != RX_IDLE);

endmodule

/* design/response_fifo.sv */
module response_fifo #(
	parameter int DEPTH_BYTES = 128
) (
	rfifo_if.fifo wr,
	input logic clock,
	input logic rst_n,
	input logic rd_en,
	output logic [at_resp_pkg::WORD_W-1:0] rd_data,
	output logic [$clog2(DEPTH_BYTES)-1:0] rd_count,
	output logic overflow
);
	import at_resp_pkg::*;

	localparam int AW = $clog2(DEPTH_BYTES);

	logic [BYTE_W-1:0] mem [DEPTH_BYTES];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr; // Always even.
	logic [AW:0] fill;
	logic [AW-1:0] head_addr;
	logic [AW-1:0] tail_addr;
	logic push;
	logic pop;

	assign fill = wr_ptr - rd_ptr;
	assign push = wr.wr_en && !wr.full;
	assign pop = rd_en && !wr.empty;

	assign wr.wr_count = fill;
	assign wr.full = (fill == (AW + 1)'(DEPTH_BYTES));
	assign wr.empty = (fill[AW:1] == '0); // A lone byte is not a word yet.
	assign rd_count = fill[AW:1];

	assign head_addr = rd_ptr[AW-1:0];
	assign tail_addr = wr_ptr[AW-1:0];

	// First byte of the pair goes high.
	assign rd_data = {mem[head_addr], mem[head_addr | AW'(1)]};

	always_ff @(posedge clock) begin
		if (push)
			mem[tail_addr] <= wr.wr_data;
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			overflow <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + (AW + 1)'(2);
			if (wr.wr_en && wr.full)
				overflow <= 1'b1; // Sticky until reset.
		end
	end

endmodule

/* design/handle_at_response.sv */
module handle_at_response #(
	parameter int CPD = 50,
	parameter int BYTE_SPACING = 12
) (
	input logic clock,
	input logic rst_n,
	input logic start,
	input logic rx_valid,
	input logic rx_busy,
	input logic [at_resp_pkg::BYTE_W-1:0] rx_data,
	rfifo_if.writer wr,
	output logic at_response_flag
);
	import at_resp_pkg::*;

	localparam logic [CNT_W-1:0] TICK_LAST = CNT_W'(CPD - 1);
	localparam logic [CNT_W-1:0] SILENCE_LAST = CNT_W'(BYTE_SPACING - 1);

	at_state_t state;
	at_state_t state_next;
	logic [CNT_W-1:0] prescale; // Cycles within one bit time.
	logic [CNT_W-1:0] silence; // Quiet bit times.
	logic bit_tick;
	logic silence_done;
	logic capturing;
	logic parity_odd; // Bytes stored in this response.
	logic pad_write;

	assign capturing = (state == ARMED) || (state == COLLECT);
	assign bit_tick = (prescale == TICK_LAST);
	assign silence_done = (state == COLLECT) && !rx_busy && bit_tick &&
		(silence == SILENCE_LAST);

	// No room left means the filler would be dropped anyway.
	assign pad_write = (state == PAD) && !wr.full;

	always_comb begin
		state_next = state;
		case (state)
		IDLE: begin
			if (start)
				state_next = ARMED;
		end
		ARMED: begin
			if (!start && rx_valid)
				state_next = COLLECT; // First byte.
		end
		COLLECT: begin
			if (start)
				state_next = ARMED;
			else if (silence_done)
				state_next = parity_odd ? PAD : DONE;
		end
		PAD: state_next = DONE;
		DONE: begin
			if (start)
				state_next = ARMED;
		end
		default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= IDLE;
			parity_odd <= 1'b0;
			wr.wr_en <= 1'b0;
		end else begin
			state <= state_next;
			wr.wr_en <= (capturing && rx_valid && !start) || pad_write;
			if (start)
				parity_odd <= 1'b0;
			else if (wr.wr_en && !wr.full)
				parity_odd <= ~parity_odd;
		end
	end

	always_ff @(posedge clock) begin
		if (state == PAD)
			wr.wr_data <= '0;
		else if (rx_valid)
			wr.wr_data <= rx_data;
	end

	// Counts only while the line is idle in COLLECT.
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			prescale <= '0;
			silence <= '0;
		end else if (state != COLLECT || rx_busy || rx_valid) begin
			prescale <= '0;
			silence <= '0;
		end else if (bit_tick) begin
			prescale <= '0;
			silence <= silence + 1'b1;
		end else begin
			prescale <= prescale + 1'b1;
		end
	end

	assign at_response_flag = (state == DONE);

endmodule

/* design/at_response_top.sv */
module at_response_top #(
	parameter int CPD = 50,
	parameter int BYTE_SPACING = 12,
	parameter int DEPTH_BYTES = 128
) (
	input logic clock,
	input logic rst_n,
	input logic start,
	input logic rx_line,
	input logic rfifo_rd_en,
	output logic [15:0] rfifo_out,
	output logic [7:0] rfifo_wr_count,
	output logic [6:0] rfifo_rd_count,
	output logic rfifo_full,
	output logic rfifo_empty,
	output logic rfifo_overflow,
	output logic at_response_flag
);
	import at_resp_pkg::*;

	logic [BYTE_W-1:0] rx_data;
	logic rx_valid;
	logic rx_busy;

	rfifo_if #(.DEPTH_BYTES(DEPTH_BYTES)) rfifo ();

	uart_rx #(.CPD(CPD)) i_uart_rx (
		.clock(clock),
		.rst_n(rst_n),
		.rx_line(rx_line),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.rx_busy(rx_busy)
	);

	handle_at_response #(
		.CPD(CPD),
		.BYTE_SPACING(BYTE_SPACING)
	) i_handle_at_response (
		.clock(clock),
		.rst_n(rst_n),
		.start(start),
		.rx_valid(rx_valid),
		.rx_busy(rx_busy),
		.rx_data(rx_data),
		.wr(rfifo.writer),
		.at_response_flag(at_response_flag)
	);

	response_fifo #(.DEPTH_BYTES(DEPTH_BYTES)) i_response_fifo (
		.wr(rfifo.fifo),
		.clock(clock),
		.rst_n(rst_n),
		.rd_en(rfifo_rd_en),
		.rd_data(rfifo_out),
		.rd_count(rfifo_rd_count),
		.overflow(rfifo_overflow)
	);

	assign rfifo_wr_count = rfifo.wr_count;
	assign rfifo_full = rfifo.full;
	assign rfifo_empty = rfifo.empty;

endmodule

/* sim/at_response_assertions.sv */
module at_response_assertions (
	input logic clock,
	input logic rst_n,
	input logic rfifo_rd_en,
	input logic rfifo_empty,
	input logic [7:0] rfifo_wr_count,
	input logic [6:0] rfifo_rd_count,
	input logic rx_busy,
	input logic at_response_flag
);
	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0; // Failed assertions.

	flag_low_after_reset: assert property (@(posedge clock)
		!rst_n |=> !at_response_flag)
		else begin
			fail_count = fail_count + 1;
			$error("at_response_flag high in the cycle after reset");
		end

	// Only a concurrent write may raise the count.
	no_pop_when_empty: assert property (@(posedge clock) disable iff (!rst_n)
		rfifo_rd_en && rfifo_empty |=>
		8'(rfifo_wr_count - $past(rfifo_wr_count)) <= 8'd1)
		else begin
			fail_count = fail_count + 1;
			$error("a pop was accepted while the FIFO was empty");
		end

	counts_agree: assert property (@(posedge clock) disable iff (!rst_n)
		rfifo_rd_count == rfifo_wr_count[7:1])
		else begin
			fail_count = fail_count + 1;
			$error("rfifo_rd_count is not half of rfifo_wr_count");
		end

	flag_outside_character: assert property (@(posedge clock) disable iff (!rst_n)
		$rose(at_response_flag) |-> !rx_busy)
		else begin
			fail_count = fail_count + 1;
			$error("at_response_flag rose during a character");
		end

endmodule

bind at_response_top at_response_assertions i_at_response_assertions (
	.clock(clock),
	.rst_n(rst_n),
	.rfifo_rd_en(rfifo_rd_en),
	.rfifo_empty(rfifo_empty),
	.rfifo_wr_count(rfifo_wr_count),
	.rfifo_rd_count(rfifo_rd_count),
	.rx_busy(rx_busy),
	.at_response_flag(at_response_flag)
);

/* sim/tb_at_response.sv */
module tb_at_response;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CPD = 50;
	localparam int BYTE_SPACING = 12;
	localparam int DEPTH_BYTES = 128;
	localparam int TOTAL_BYTES = 150; // All characters sent by the tests.
	localparam int RESPONSES = 6;
	// 11 bit times per byte, silence per response, two long gaps, 25% margin.
	localparam int MAX_CYCLES =
		(TOTAL_BYTES * 11 + RESPONSES * (BYTE_SPACING + 2) + 12) * CPD * 5 / 4;

	logic clock = 1'b0;
	logic rst_n;
	logic start;
	logic rx_line;
	logic rfifo_rd_en;
	logic [15:0] rfifo_out;
	logic [7:0] rfifo_wr_count;
	logic [6:0] rfifo_rd_count;
	logic rfifo_full;
	logic rfifo_empty;
	logic rfifo_overflow;
	logic at_response_flag;

	int errors = 0;
	int cycles = 0;
	integer seed;
	logic [15:0] expected[$]; // Words in arrival order.
	logic [7:0] held_byte;
	logic have_half;

	at_response_top #(
		.CPD(CPD),
		.BYTE_SPACING(BYTE_SPACING),
		.DEPTH_BYTES(DEPTH_BYTES)
	) i_at_response_top (
		.clock(clock),
		.rst_n(rst_n),
		.start(start),
		.rx_line(rx_line),
		.rfifo_rd_en(rfifo_rd_en),
		.rfifo_out(rfifo_out),
		.rfifo_wr_count(rfifo_wr_count),
		.rfifo_rd_count(rfifo_rd_count),
		.rfifo_full(rfifo_full),
		.rfifo_empty(rfifo_empty),
		.rfifo_overflow(rfifo_overflow),
		.at_response_flag(at_response_flag)
	);

	always #4 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the response never completed", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic compare_value(input string name, input logic [15:0] actual,
		input logic [15:0] want);
		assert (actual === want) else begin
			errors++;
			$display("FAIL %0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, want);
		end
	endtask

	task automatic require(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			errors++;
			$display("ERROR %0t: %s", $time, what);
		end
	endtask

	// 8N1, LSB first, then gap_bits of idle line.
	task automatic serialize_byte(input logic [7:0] value, input int gap_bits,
		input logic stop_bit);
		int i;
		rx_line = 1'b0;
		repeat (CPD) @(negedge clock);
		for (i = 0; i < 8; i++) begin
			rx_line = value[i];
			repeat (CPD) @(negedge clock);
		end
		rx_line = stop_bit;
		repeat (CPD) @(negedge clock);
		rx_line = 1'b1;
		repeat (gap_bits * CPD) @(negedge clock);
	endtask

	// First byte of a pair is the upper half.
	task automatic note_byte(input logic [7:0] value);
		if (have_half) begin
			expected.push_back({held_byte, value});
			have_half = 1'b0;
		end else begin
			held_byte = value;
			have_half = 1'b1;
		end
	endtask

	task automatic transmit_byte(input logic [7:0] value, input int gap_bits);
		note_byte(value);
		serialize_byte(value, gap_bits, 1'b1);
	endtask

	task automatic pulse_start();
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		have_half = 1'b0;
	endtask

	task automatic wait_for_flag();
		while (!at_response_flag)
			@(negedge clock);
		@(negedge clock); // Padding byte lands one cycle later.
	endtask

	task automatic pop_word();
		logic [15:0] want;
		if (expected.size() == 0) begin
			require(1'b0, "no expected word left to compare");
		end else begin
			want = expected.pop_front();
			require(!rfifo_empty, "FIFO empty while a word was expected");
			compare_value("rfifo_out", rfifo_out, want);
			rfifo_rd_en = 1'b1;
			@(negedge clock);
			rfifo_rd_en = 1'b0;
		end
	endtask

	// Read strobe with less than a word held, to be ignored.
	task automatic pop_while_empty(input logic [7:0] bytes_held);
		require(rfifo_empty, "FIFO not empty before the ignored pop");
		rfifo_rd_en = 1'b1;
		@(negedge clock);
		rfifo_rd_en = 1'b0;
		compare_value("rfifo_wr_count", 16'(rfifo_wr_count), 16'(bytes_held));
		require(rfifo_empty, "FIFO not empty after the ignored pop");
	endtask

	initial begin
		logic [7:0] value;
		logic [7:0] count_before;
		int i;
		int total;
		rst_n = 1'b0;
		start = 1'b0;
		rx_line = 1'b1; // Idle line.
		rfifo_rd_en = 1'b0;
		seed = 78800;
		have_half = 1'b0;
		held_byte = 8'h00;
		repeat (4) @(negedge clock);
		rst_n = 1'b1;
		@(negedge clock);
		require(!at_response_flag, "flag high after reset");
		require(rfifo_empty, "FIFO not empty after reset");
		require(!rfifo_overflow, "overflow set after reset");

		$display("Test 1: OK reply");
		pulse_start();
		transmit_byte(8'h4F, 1); // O
		transmit_byte(8'h4B, 1); // K
		wait_for_flag();
		pop_word();
		require(rfifo_empty, "FIFO not empty after the OK word was read");
		pop_while_empty(8'd0);

		$display("Test 2: odd-length reply");
		pulse_start();
		transmit_byte(8'h45, 1); // E
		transmit_byte(8'h52, 1);
		transmit_byte(8'h52, 1);
		transmit_byte(8'h4F, 1);
		transmit_byte(8'h52, 1);
		note_byte(8'h00);
		wait_for_flag();
		compare_value("rfifo_rd_count", 16'(rfifo_rd_count), 16'd3);
		repeat (3) pop_word();

		$display("Test 3: gap shorter than the limit");
		pulse_start();
		transmit_byte(8'h31, BYTE_SPACING - 4);
		require(!at_response_flag, "flag rose inside a short gap");
		pop_while_empty(8'd1); // Lone byte is not a word.
		transmit_byte(8'h32, 1);
		wait_for_flag();
		pop_word();

		$display("Test 4: re-arming");
		pulse_start();
		require(!at_response_flag, "flag still high after start");
		for (i = 0; i < 8; i++) begin
			value = 8'($random(seed));
			transmit_byte(value, 1);
		end
		wait_for_flag();
		repeat (4) pop_word();

		$display("Test 5: framing error");
		pulse_start();
		count_before = rfifo_wr_count;
		serialize_byte(8'h55, 4, 1'b0);
		compare_value("rfifo_wr_count", 16'(rfifo_wr_count), 16'(count_before));
		transmit_byte(8'h41, 1); // A
		transmit_byte(8'h54, 1); // T
		wait_for_flag();
		pop_word();

		$display("Test 6: overflow");
		pulse_start();
		for (i = 0; i < DEPTH_BYTES + 2; i++) begin
			value = 8'($random(seed));
			if (i < DEPTH_BYTES)
				note_byte(value);
			serialize_byte(value, 1, 1'b1);
		end
		wait_for_flag();
		require(rfifo_full, "FIFO not full after 130 bytes");
		require(rfifo_overflow, "overflow not set after 130 bytes");
		repeat (DEPTH_BYTES / 2) pop_word();
		require(rfifo_empty, "FIFO not empty after 64 words were read");
		require(expected.size() == 0, "expected words left over");

		total = errors + i_at_response_top.i_at_response_assertions.fail_count;
		$display("Errors: %0d in checks, %0d in assertions", errors,
			i_at_response_top.i_at_response_assertions.fail_count);
		if (total == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* sim.f */
design/at_resp_pkg.sv
design/rfifo_if.sv
design/uart_rx.sv
design/response_fifo.sv
design/handle_at_response.sv
design/at_response_top.sv
sim/at_response_assertions.sv
sim/tb_at_response.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AT response testbench with Verilator.
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module tb_at_response -f sim.f -o sim_at_response
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_at_response +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	exit 0
fi
exit 1
